//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_pdp1_tape_loader
FILELIST  = pdp1_tape.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
PASS_MSG  = SIMULATION PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- pdp1_tape.f
+incdir+verilog
verilog/pdp1_tape_pkg.sv
verilog/tape_frame_assembler.sv
verilog/tape_timeout_timer.sv
verilog/tape_loader_fsm.sv
verilog/pdp1_tape_loader.sv
sim/tape_checker.sv
sim/tb_pdp1_tape_loader.sv

//--- sim/tape_checker.sv
/* Watches the tape loader ports for the testbench. Compares requested port snapshots
   and matches every memory write against a queue of expected writes */
`timescale 1ns/10ps

module tape_checker import pdp1_tape_pkg::*; (
   input  logic       CLK_50M,
   input  logic       rst_n,
   input  logic       tape_wait,
   input  pdp1_word_t rcv_word,
   input  pdp1_addr_t start_address,
   input  mem_write_t mem_write,
   input  logic       rim_active,
   input  logic       check_req,
   input  logic       exp_wait,
   input  pdp1_word_t exp_word,
   input  pdp1_addr_t exp_start,
   input  logic       exp_rim,
   input  logic       wr_push,
   input  mem_write_t exp_wr,
   input  logic       end_req,
   output int         value_errors,
   output int         write_errors,
   output int         writes_seen
);

   mem_write_t pending[$];
   mem_write_t want;
   int         value_count = 0;
   int         write_count = 0;
   int         seen_count  = 0;

   assign value_errors = value_count;
   assign write_errors = write_count;
   assign writes_seen  = seen_count;

   // One field of a snapshot, widened so every port fits the same compare
   task automatic compare_field(input string what, input logic [17:0] got,
                                input logic [17:0] exp);
      if (got !== exp) begin
         $display("FAIL at %0t: %s is %h, expected %h", $time, what, got, exp);
         value_count++;
      end
   endtask

   // ==============================
   // Sampling on the falling edge
   // ==============================

   // Outputs and testbench requests both settle by mid-cycle
   always @(negedge CLK_50M) begin
      if (wr_push) begin
         pending.push_back(exp_wr);
      end

      // Each strobe consumes the oldest expected write
      if (rst_n && mem_write.strobe === 1'b1) begin
         seen_count++;
         if (pending.size() == 0) begin
            $display("Unexpected memory write of %h to address %h at time %0t",
                     mem_write.data, mem_write.addr, $time);
            write_count++;
         end else begin
            want = pending.pop_front();
            if (mem_write.addr !== want.addr || mem_write.data !== want.data) begin
               $display("FAIL at %0t: memory write %h <= %h, expected %h <= %h", $time,
                        mem_write.addr, mem_write.data, want.addr, want.data);
               write_count++;
            end
         end
      end

      if (check_req) begin
         compare_field("tape_wait", {17'd0, tape_wait}, {17'd0, exp_wait});
         compare_field("rcv_word", rcv_word, exp_word);
         compare_field("start_address", {6'd0, start_address}, {6'd0, exp_start});
         compare_field("rim_active", {17'd0, rim_active}, {17'd0, exp_rim});
      end

      // Leftover entries are dio frames that never reached memory
      if (end_req && pending.size() != 0) begin
         $display("%0d expected memory writes never happened", pending.size());
         write_count += pending.size();
      end
   end

endmodule

//--- sim/tape_vectors.txt
# Command letter then hex fields: B byte, D download, N next_char, I idle cycles, E/X rim pulses
# M addr data queues a memory write; W tape_wait rcv_word start_address rim_active
W 0 00000 004 0
D 1
B 8A
B 9C
B AE
W 1 0A72E 004 0
N 1
N 0
W 0 0A72E 004 0
B B7
B 3F
B 81
B 7F
B C5
W 1 37045 004 0
N 1
N 0
W 0 37045 004 0
B A0
B 90
B 88
W 1 20408 004 0
I 50
W 0 20408 004 0
B 8F
B 8F
B 8F
W 1 0F3CF 004 0
D 0
W 0 0F3CF 004 0
D 1
E
W 0 0F3CF 004 1
M 123 2ABCD
B 9A
B 84
B A3
B AA
B AF
B 8D
W 0 0F3CF 004 1
B 90
B BF
B BF
B BF
B BF
B BF
W 0 0F3CF 004 1
B B0
B 82
B A5
B 95
B 95
B 95
W 1 15555 0A5 0
N 1
N 0
W 0 15555 0A5 0
E
W 0 15555 0A5 1
X
W 0 15555 0A5 0
B 81
B 82
B 83
W 1 01083 0A5 0
N 1
N 0
W 0 01083 0A5 0

//--- sim/tb_pdp1_tape_loader.sv
/* Testbench of the tape loader. Replays sim/tape_vectors.txt against the DUT while
   tape_checker compares the ports and the memory writes */
`timescale 1ns/10ps

module tb_pdp1_tape_loader import pdp1_tape_pkg::*; ();

   logic       CLK_50M;
   logic       rst_n;
   logic       download;
   logic       byte_strobe;
   logic [7:0] tape_byte;
   logic       rim_enable;
   logic       rim_disable;
   logic       next_char;
   logic       tape_wait;
   pdp1_word_t rcv_word;
   pdp1_addr_t start_address;
   mem_write_t mem_write;
   logic       rim_active;

   // Requests towards the checker
   logic       check_req;
   logic       exp_wait;
   pdp1_word_t exp_word;
   pdp1_addr_t exp_start;
   logic       exp_rim;
   logic       wr_push;
   mem_write_t exp_wr;
   logic       end_req;
   int         value_errors;
   int         write_errors;
   int         writes_seen;

   // Commands read from the vector file, one entry per line
   logic [7:0]  cmd_q[$];
   logic [31:0] a_q[$];
   logic [31:0] b_q[$];
   logic [31:0] c_q[$];
   logic [31:0] d_q[$];
   int          cmd_errors  = 0;
   int          cycle_count = 0;
   int          cycle_limit = 200;
   bit          loaded;

   pdp1_tape_loader #(.TIMEOUT_CYCLES(64)) i_dut (.*);

   tape_checker i_checker (.*);

   always #10 CLK_50M = ~CLK_50M;

   // Stops a run that hangs on a handshake
   always @(posedge CLK_50M) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= cycle_limit) begin
         $display("Run stopped after %0d cycles before the vectors were done", cycle_count);
         $display("SIMULATION FAILED");
         $finish;
      end
   end

   // ==============================
   // Vector file
   // ==============================

   // Bytes are costed at their worst gap, the limit is four times the sum plus slack
   task automatic load_vectors(output bit ok);
      int          fd;
      int          r;
      int          total;
      logic [7:0]  cmd;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] c;
      logic [31:0] d;
      logic [2047:0] rest;
      ok    = 1'b0;
      total = 0;
      fd    = $fopen("sim/tape_vectors.txt", "r");
      if (fd != 0) begin
         ok = 1'b1;
         r  = $fscanf(fd, " %c", cmd);
         while (r == 1) begin
            a = '0;
            b = '0;
            c = '0;
            d = '0;
            case (cmd)
               "#": r = $fgets(rest, fd);
               "B", "D", "N", "I": r = $fscanf(fd, "%h", a);
               "M": r = $fscanf(fd, "%h %h", a, b);
               "W": r = $fscanf(fd, "%h %h %h %h", a, b, c, d);
               default: r = 0;
            endcase
            if (cmd != "#") begin
               cmd_q.push_back(cmd);
               a_q.push_back(a);
               b_q.push_back(b);
               c_q.push_back(c);
               d_q.push_back(d);
               if (cmd == "B") total += 4;
               else if (cmd == "I") total += int'(a);
               else total += 2;
            end
            r = $fscanf(fd, " %c", cmd);
         end
         $fclose(fd);
      end
      cycle_limit = 4 * total + 200;
   endtask

   // ==============================
   // Stimulus
   // ==============================

   // Strobe for one cycle, then 1 to 3 idle cycles
   task automatic strobe_byte(input logic [7:0] value);
      int gap;
      gap = $urandom % 3;
      @(posedge CLK_50M);
      byte_strobe <= 1'b1;
      tape_byte   <= value;
      @(posedge CLK_50M);
      byte_strobe <= 1'b0;
      repeat (gap) @(posedge CLK_50M);
   endtask

   task automatic pulse_rim(input logic enable);
      @(posedge CLK_50M);
      rim_enable  <= enable;
      rim_disable <= ~enable;
      @(posedge CLK_50M);
      rim_enable  <= 1'b0;
      rim_disable <= 1'b0;
   endtask

   task automatic expect_write(input pdp1_addr_t addr, input pdp1_word_t data);
      @(posedge CLK_50M);
      exp_wr  <= '{strobe: 1'b1, addr: addr, data: data};
      wr_push <= 1'b1;
      @(posedge CLK_50M);
      wr_push <= 1'b0;
   endtask

   // The checker samples the snapshot on the falling edge in between
   task automatic request_check(input logic w, input pdp1_word_t word,
                                input pdp1_addr_t start, input logic rim);
      @(posedge CLK_50M);
      exp_wait  <= w;
      exp_word  <= word;
      exp_start <= start;
      exp_rim   <= rim;
      check_req <= 1'b1;
      @(posedge CLK_50M);
      check_req <= 1'b0;
   endtask

   task automatic run_command(input logic [7:0] cmd, input logic [31:0] a, input logic [31:0] b,
                              input logic [31:0] c, input logic [31:0] d);
      case (cmd)
         "B": strobe_byte(a[7:0]);
         "E": pulse_rim(1'b1);
         "X": pulse_rim(1'b0);
         "I": repeat (a) @(posedge CLK_50M);
         "M": expect_write(a[11:0], b[17:0]);
         "W": request_check(a[0], b[17:0], c[11:0], d[0]);
         "D": begin
            @(posedge CLK_50M);
            download <= a[0];
         end
         "N": begin
            @(posedge CLK_50M);
            next_char <= a[0];
         end
         default: begin
            $display("Vector file holds an unknown command '%c'", cmd);
            cmd_errors++;
         end
      endcase
   endtask

   initial begin
      CLK_50M     = 1'b0;
      rst_n       = 1'b0;
      download    = 1'b0;
      byte_strobe = 1'b0;
      tape_byte   = 8'h00;
      rim_enable  = 1'b0;
      rim_disable = 1'b0;
      next_char   = 1'b0;
      check_req   = 1'b0;
      exp_wait    = 1'b0;
      exp_word    = '0;
      exp_start   = '0;
      exp_rim     = 1'b0;
      wr_push     = 1'b0;
      exp_wr      = '0;
      end_req     = 1'b0;
      void'($urandom(63));
      load_vectors(loaded);
      if (!loaded) begin
         $display("Vector file sim/tape_vectors.txt could not be opened");
         $display("SIMULATION FAILED");
         $finish;
      end else begin
         repeat (5) @(posedge CLK_50M);
         rst_n <= 1'b1;
         for (int i = 0; i < cmd_q.size(); i++) begin
            run_command(cmd_q[i], a_q[i], b_q[i], c_q[i], d_q[i]);
         end
         repeat (4) @(posedge CLK_50M);
         end_req <= 1'b1;
         @(posedge CLK_50M);
         end_req <= 1'b0;
         @(posedge CLK_50M);
         $display("Errors: %0d value, %0d write, %0d vector; %0d memory writes seen",
                  value_errors, write_errors, cmd_errors, writes_seen);
         if (value_errors + write_errors + cmd_errors == 0) begin
            $display("SIMULATION PASSED");
         end else begin
            $display("SIMULATION FAILED");
         end
         $finish;
      end
   end

endmodule

//--- verilog/pdp1_tape_loader.sv
/* Top of the paper-tape loader. Connects the frame assembler, the download timeout
   and the loader FSM; outputs appear two clocks after the completing byte strobe */
`timescale 1ns/10ps
`include "pdp1_tape_params.svh"

module pdp1_tape_loader import pdp1_tape_pkg::*; #(
   parameter int unsigned TIMEOUT_CYCLES = `TAPE_TIMEOUT_CYCLES
) (
   input  logic       CLK_50M,
   input  logic       rst_n,
   input  logic       download,
   input  logic       byte_strobe,
   input  logic [7:0] tape_byte,
   input  logic       rim_enable,
   input  logic       rim_disable,
   input  logic       next_char,
   output logic       tape_wait,
   output pdp1_word_t rcv_word,
   output pdp1_addr_t start_address,
   output mem_write_t mem_write,
   output logic       rim_active
);

   // ==============================
   // Internal links
   // ==============================

   logic        frame_valid;
   tape_frame_u frame;
   logic        restart;
   logic        expired;

   // Assembler already merges accepted bytes with the download start
   tape_frame_assembler i_assembler (
      .CLK_50M     (CLK_50M),
      .rst_n       (rst_n),
      .download    (download),
      .byte_strobe (byte_strobe),
      .tape_byte   (tape_byte),
      .rim_active  (rim_active),
      .frame_valid (frame_valid),
      .frame       (frame),
      .byte_taken  (restart)
   );

   tape_timeout_timer #(
      .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
   ) i_timer (
      .CLK_50M (CLK_50M),
      .rst_n   (rst_n),
      .restart (restart),
      .expired (expired)
   );

   // Mode output feeds back to the assembler to pick the frame length
   tape_loader_fsm i_fsm (
      .CLK_50M       (CLK_50M),
      .rst_n         (rst_n),
      .download      (download),
      .next_char     (next_char),
      .rim_enable    (rim_enable),
      .rim_disable   (rim_disable),
      .frame_valid   (frame_valid),
      .frame         (frame),
      .expired       (expired),
      .tape_wait     (tape_wait),
      .rcv_word      (rcv_word),
      .start_address (start_address),
      .mem_write     (mem_write),
      .rim_active    (rim_active)
   );

endmodule

//--- verilog/pdp1_tape_params.svh
/* Shared constants of the paper-tape loader: frame lengths, RIM opcodes, reset start
   address and download timeout. Include this file wherever one of them is needed */
`ifndef PDP1_TAPE_PARAMS_SVH
`define PDP1_TAPE_PARAMS_SVH

// Payload bits carried by every tape byte, bit 7 only marks the byte as valid
`define TAPE_BITS_PER_BYTE 6

// Bytes that make one 18-bit binary word
`define TAPE_BINARY_BYTES 3

// Bytes that make one 36-bit read-in frame
`define TAPE_RIM_BYTES 6

// Read-in opcodes that the loader acts on, all others are skipped
`define TAPE_OP_JMP 6'o60
`define TAPE_OP_DIO 6'o32

// The CPU starts here until a jmp frame says otherwise
`define TAPE_DEFAULT_START 12'd4

// One second of CLK_50M without a byte aborts a stuck download
`define TAPE_TIMEOUT_CYCLES 50000000

`endif

//--- verilog/pdp1_tape_pkg.sv
/* Types shared by the tape loader modules and the testbench: machine word, address,
   the two views of an assembled frame, the memory write bundle and the FSM state */
package pdp1_tape_pkg;

   // PDP-1 machine word and core address
   typedef logic [17:0] pdp1_word_t;
   typedef logic [11:0] pdp1_addr_t;

   // ==============================
   // Assembled tape frame
   // ==============================

   // One 36-bit buffer read two ways
   // In read-in mode the top six bits are an opcode followed by address and data
   // In binary mode only the low word is filled, the upper half stays zero
   typedef union packed {
      struct packed {
         logic [5:0] opcode;
         pdp1_addr_t addr;
         pdp1_word_t data;
      } rim;
      struct packed {
         pdp1_word_t unused;
         pdp1_word_t word;
      } bin;
   } tape_frame_u;

   // Write port into main memory, strobe is a single-cycle pulse
   typedef struct packed {
      logic       strobe;
      pdp1_addr_t addr;
      pdp1_word_t data;
   } mem_write_t;

   // Loader modes, the hold state is where tape_wait is raised
   typedef enum logic [1:0] {
      BINARY_RECV,
      BINARY_HOLD,
      RIM_RECV
   } loader_state_e;

endpackage

//--- verilog/tape_frame_assembler.sv
/* Collects marked tape bytes into a shift buffer and hands out a finished frame after
   three bytes in binary mode or six in read-in mode */
`timescale 1ns/10ps
`include "pdp1_tape_params.svh"

module tape_frame_assembler import pdp1_tape_pkg::*; (
   input  logic        CLK_50M,
   input  logic        rst_n,
   input  logic        download,
   input  logic        byte_strobe,
   input  logic [7:0]  tape_byte,
   input  logic        rim_active,
   output logic        frame_valid,
   output tape_frame_u frame,
   output logic        byte_taken
);

   localparam int BPB     = `TAPE_BITS_PER_BYTE;
   localparam int FRAME_W = `TAPE_RIM_BYTES * `TAPE_BITS_PER_BYTE;

   localparam logic [2:0] BIN_LEN = 3'(`TAPE_BINARY_BYTES);
   localparam logic [2:0] RIM_LEN = 3'(`TAPE_RIM_BYTES);

   logic               download_q;
   logic               download_rise;
   logic               accept;
   logic               complete;
   logic [2:0]         count;
   logic [2:0]         frame_len;
   logic [FRAME_W-1:0] buffer;
   logic [FRAME_W-1:0] shifted;

   // A byte counts only when the strobe comes with bit 7 set
   assign download_rise = download & ~download_q;
   assign accept        = byte_strobe & tape_byte[7];

   // The timer restarts on a new download and on every byte we keep
   assign byte_taken = accept | download_rise;

   // Frame length follows the current mode
   assign frame_len = rim_active ? RIM_LEN : BIN_LEN;

   // Greater-or-equal so that a mode change in mid-frame cannot wrap the counter
   assign complete = (count >= frame_len - 3'd1);

   // Oldest group ends up in the upper bits
   assign shifted = {buffer[FRAME_W-BPB-1:0], tape_byte[BPB-1:0]};

   // ==============================
   // Byte counter and frame pulse
   // ==============================

   always_ff @(posedge CLK_50M or negedge rst_n) begin
      if (!rst_n) begin
         download_q  <= 1'b0;
         count       <= '0;
         frame_valid <= 1'b0;
      end else begin
         download_q  <= download;
         frame_valid <= 1'b0;
         if (download_rise) begin
            count <= '0;
         end else if (accept) begin
            if (complete) begin
               count       <= '0;
               frame_valid <= 1'b1;
            end else begin
               count <= count + 3'd1;
            end
         end
      end
   end

   // Shift buffer and the frame register, only read while frame_valid is high
   always_ff @(posedge CLK_50M) begin
      if (download_rise) begin
         buffer <= '0;
      end else if (accept) begin
         if (complete) begin
            frame  <= shifted;
            buffer <= '0;
         end else begin
            buffer <= shifted;
         end
      end
   end

   // Every frame needs at least one more byte, so pulses never merge
   a_single_frame_pulse: assert property (@(posedge CLK_50M) disable iff (!rst_n)
      frame_valid |=> !frame_valid);

endmodule

//--- verilog/tape_loader_fsm.sv
/* Mode and wait control of the tape loader. Binary frames become words for the CPU,
   read-in frames are decoded into memory writes and the final jump */
`timescale 1ns/10ps
`include "pdp1_tape_params.svh"

module tape_loader_fsm import pdp1_tape_pkg::*; (
   input  logic        CLK_50M,
   input  logic        rst_n,
   input  logic        download,
   input  logic        next_char,
   input  logic        rim_enable,
   input  logic        rim_disable,
   input  logic        frame_valid,
   input  tape_frame_u frame,
   input  logic        expired,
   output logic        tape_wait,
   output pdp1_word_t  rcv_word,
   output pdp1_addr_t  start_address,
   output mem_write_t  mem_write,
   output logic        rim_active
);

   loader_state_e state;
   logic          next_char_q;
   logic          next_char_fall;
   logic          release_wait;

   // The CPU drops next_char once it has consumed the word
   assign next_char_fall = next_char_q & ~next_char;

   // A timeout or the end of the download also frees the byte source
   assign release_wait = next_char_fall | expired | ~download;

   // Both levels come straight from the state register
   assign tape_wait  = (state == BINARY_HOLD);
   assign rim_active = (state == RIM_RECV);

   // ==============================
   // State and outputs
   // ==============================

   always_ff @(posedge CLK_50M or negedge rst_n) begin
      if (!rst_n) begin
         state         <= BINARY_RECV;
         next_char_q   <= 1'b0;
         rcv_word      <= '0;
         start_address <= `TAPE_DEFAULT_START;
         mem_write     <= '0;
      end else begin
         next_char_q      <= next_char;
         mem_write.strobe <= 1'b0;

         // Menu pulses override whatever the tape is doing
         if (rim_enable) begin
            state <= RIM_RECV;
         end else if (rim_disable) begin
            state <= BINARY_RECV;
         end else begin
            case (state)
               BINARY_RECV: begin
                  if (frame_valid) begin
                     rcv_word <= frame.bin.word;
                     state    <= BINARY_HOLD;
                  end
               end

               BINARY_HOLD: begin
                  // A late byte that completes a word refreshes it and keeps the hold
                  if (frame_valid) begin
                     rcv_word <= frame.bin.word;
                  end else if (release_wait) begin
                     state <= BINARY_RECV;
                  end
               end

               RIM_RECV: begin
                  if (frame_valid) begin
                     case (frame.rim.opcode)
                        `TAPE_OP_DIO: begin
                           mem_write.strobe <= 1'b1;
                           mem_write.addr   <= frame.rim.addr;
                           mem_write.data   <= frame.rim.data;
                        end
                        // Jump ends the read-in and hands its word to the CPU
                        `TAPE_OP_JMP: begin
                           start_address <= frame.rim.addr;
                           rcv_word      <= frame.rim.data;
                           state         <= BINARY_HOLD;
                        end
                        default: begin
                           // Other opcodes are skipped on the tape
                        end
                     endcase
                  end
               end

               default: state <= BINARY_RECV;
            endcase
         end
      end
   end

   // Writes come only out of a read-in frame decoded in the cycle before
   a_write_from_rim: assert property (@(posedge CLK_50M) disable iff (!rst_n)
      mem_write.strobe |-> $past(state == RIM_RECV));

endmodule

//--- verilog/tape_timeout_timer.sv
/* Saturating cycle counter that flags a stalled download when no byte has arrived
   for TIMEOUT_CYCLES clocks */
`timescale 1ns/10ps
`include "pdp1_tape_params.svh"

module tape_timeout_timer #(
   parameter int unsigned TIMEOUT_CYCLES = `TAPE_TIMEOUT_CYCLES
) (
   input  logic CLK_50M,
   input  logic rst_n,
   input  logic restart,
   output logic expired
);

   localparam int W = $clog2(TIMEOUT_CYCLES + 1);
   localparam logic [W-1:0] LIMIT = W'(TIMEOUT_CYCLES);

   logic [W-1:0] count;

   // ==============================
   // Counter
   // ==============================

   // Restart wins, otherwise count up and stop at the limit
   always_ff @(posedge CLK_50M or negedge rst_n) begin
      if (!rst_n) begin
         count <= '0;
      end else if (restart) begin
         count <= '0;
      end else if (count != LIMIT) begin
         count <= count + W'(1);
      end
   end

   // Stays high until the next restart
   assign expired = (count == LIMIT);

   a_count_bounded: assert property (@(posedge CLK_50M) disable iff (!rst_n)
      count <= LIMIT);

endmodule
